/* common/snowbro2_defines.svh */
// address map, I/O and GCU offsets and memory depths, included by the bus RTL and testbench
`ifndef SNOWBRO2_DEFINES_SVH
`define SNOWBRO2_DEFINES_SVH

// work RAM, 0x100000-0x10FFFF
`define SB2_WRAM_BASE   24'h100000
`define SB2_WRAM_AW     15           // 32K words

// GP9001 window, 16 bytes
`define SB2_GCU_BASE    24'h300000

// palette RAM, 0x400000-0x400FFF
`define SB2_PAL_BASE    24'h400000
`define SB2_PAL_AW      11           // 2K words

// cabinet I/O page
`define SB2_IO_BASE     24'h700000

// I/O byte offsets inside the page
`define SB2_IO_JUMPER   12'h000
`define SB2_IO_DSWA     12'h004
`define SB2_IO_DSWB     12'h008
`define SB2_IO_P1       12'h00C
`define SB2_IO_P2       12'h010
`define SB2_IO_SYS      12'h01C
`define SB2_IO_OKIBANK  12'h030      // low lane only

// GCU byte offsets
`define SB2_GCU_PTR     4'h0
`define SB2_GCU_RAM_H   4'h4
`define SB2_GCU_RAM_L   4'h6
`define SB2_GCU_SEL     4'h8
`define SB2_GCU_REG     4'hC         // reads here give video status

`endif

/* common/snowbro2_pkg.sv */
// shared bus, data and FSM types for the 68000-side glue logic and its testbench
package snowbro2_pkg;

    typedef logic [23:0] bus_addr_t;   // byte address
    typedef logic [15:0] bus_data_t;   // one bus word
    typedef logic [1:0]  byte_strb_t;  // bit 1 is the upper byte
    typedef logic [9:0]  joy_t;        // active low, as from the frame
    typedef logic [10:0] pal_addr_t;   // palette word address

    // APB slave sequencing
    typedef enum logic [1:0] {
        BUS_IDLE,   // waiting for a setup phase
        BUS_WAIT,   // first access cycle, strobes issued
        BUS_GCU,    // stalled on the graphics chip
        BUS_DONE    // pready cycle
    } bus_state_e;

    // decode result, latched at setup
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_WRAM,
        TGT_PAL,
        TGT_GCU,
        TGT_VSTAT,
        TGT_IO
    } target_e;

endpackage

/* rtl/byte_ram.sv */
// dual-port word RAM with byte writes on port 0 and a read-only port 1, one cycle read latency
module byte_ram #(
    parameter int aw = 11
) (
    input  logic                     CLK96,
    input  logic [aw-1:0]            addr0,
    input  snowbro2_pkg::bus_data_t  data0,
    input  snowbro2_pkg::byte_strb_t we0,
    input  logic [aw-1:0]            addr1,
    output snowbro2_pkg::bus_data_t  q0,
    output snowbro2_pkg::bus_data_t  q1
);

    snowbro2_pkg::bus_data_t mem [2**aw];

    always_ff @(posedge CLK96) begin
        if (we0[0]) begin
            mem[addr0][7:0] <= data0[7:0];
        end
        if (we0[1]) begin
            mem[addr0][15:8] <= data0[15:8];   // upper lane
        end
        q0 <= mem[addr0];   // old data on a write
        q1 <= mem[addr1];
    end

endmodule

/* io/cabinet_io.sv */
// cabinet inputs, DIP switches and video status formatted for the 68000, plus the OKI bank latch
`include "snowbro2_defines.svh"

module cabinet_io (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     io_rd,
    input  logic                     io_wr,
    input  logic [11:0]              io_offset,
    input  snowbro2_pkg::bus_data_t  io_wdata,
    input  snowbro2_pkg::byte_strb_t io_strb,
    input  snowbro2_pkg::joy_t       joystick1,
    input  snowbro2_pkg::joy_t       joystick2,
    input  logic [1:0]               start_button,
    input  logic [1:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               v,
    input  logic                     vstat_rd,
    output snowbro2_pkg::bus_data_t  io_rdata,
    output logic                     oki_bank
);

    logic [7:0]              p1_byte;
    logic [7:0]              p2_byte;
    logic [7:0]              sys_byte;
    snowbro2_pkg::bus_data_t video_status;

    // inputs are active low, the game wants active high
    assign p1_byte = {2'b00, ~joystick1[5], ~joystick1[4], ~joystick1[0],
                      ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_byte = {2'b00, ~joystick2[5], ~joystick2[4], ~joystick2[0],
                      ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    // sync flags in the upper byte, beam line below, saturated past 255
    assign video_status = {hsync, vsync, 5'b11111, fblank,
                           (v < 9'd256) ? v[7:0] : 8'hFF};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            io_rdata <= '0;
            oki_bank <= 1'b0;
        end else begin
            if (vstat_rd) begin
                io_rdata <= video_status;
            end else if (io_rd) begin
                case (io_offset)
                    `SB2_IO_JUMPER: io_rdata <= {2{dipsw_c}};
                    `SB2_IO_DSWA:   io_rdata <= {2{dipsw_a}};
                    `SB2_IO_DSWB:   io_rdata <= {2{dipsw_b}};
                    `SB2_IO_P1:     io_rdata <= {2{p1_byte}};
                    `SB2_IO_P2:     io_rdata <= {2{p2_byte}};
                    `SB2_IO_SYS:    io_rdata <= {dipsw_c, sys_byte};
                    default:        io_rdata <= '0;   // empty slots read zero
                endcase
            end
            if (io_wr && io_offset == `SB2_IO_OKIBANK && io_strb[0]) begin
                oki_bank <= io_wdata[0];   // sample bank select
            end
        end
    end

endmodule

/* gcu/gcu_cmd.sv */
// turns a host GCU access into one GP9001 operation strobe, held until the chip acknowledges
`include "snowbro2_defines.svh"

module gcu_cmd (
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  logic                    gcu_start,
    input  logic [3:0]              gcu_offset,
    input  logic                    gcu_read,
    input  snowbro2_pkg::bus_data_t wdata,
    input  logic                    gcu_ack,
    input  snowbro2_pkg::bus_data_t gcu_dout,
    output logic                    gcu_select_reg,
    output logic                    gcu_write_reg,
    output logic                    gcu_write_ram,
    output logic                    gcu_read_ram_h,
    output logic                    gcu_read_ram_l,
    output logic                    gcu_set_ram_ptr,
    output snowbro2_pkg::bus_data_t gcu_wdata,
    output logic                    gcu_done,
    output snowbro2_pkg::bus_data_t gcu_rdata
);

    // {select_reg, write_reg, write_ram, read_h, read_l, set_ptr}
    logic [5:0] strb;
    logic [5:0] op;
    logic       busy;

    always_comb begin
        op = 6'b000000;
        if (gcu_read) begin
            case (gcu_offset)
                `SB2_GCU_RAM_H: op = 6'b000100;
                `SB2_GCU_RAM_L: op = 6'b000010;
                default:        op = 6'b000000;
            endcase
        end else begin
            case (gcu_offset)
                `SB2_GCU_PTR:                   op = 6'b000001;
                `SB2_GCU_RAM_H, `SB2_GCU_RAM_L: op = 6'b001000;   // either half writes RAM
                `SB2_GCU_SEL:                   op = 6'b100000;
                `SB2_GCU_REG:                   op = 6'b010000;
                default:                        op = 6'b000000;
            endcase
        end
    end

    assign busy = |strb;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            strb     <= '0;
            gcu_done <= 1'b0;
        end else begin
            gcu_done <= 1'b0;
            if (gcu_start) begin
                strb <= op;
            end else if (busy && gcu_ack) begin
                strb     <= '0;
                gcu_done <= 1'b1;   // one cycle
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (gcu_start) begin
            gcu_wdata <= wdata;
        end
        if (gcu_ack && (gcu_read_ram_h || gcu_read_ram_l)) begin
            gcu_rdata <= gcu_dout;   // chip data is valid with ack
        end
    end

    assign {gcu_select_reg, gcu_write_reg, gcu_write_ram,
            gcu_read_ram_h, gcu_read_ram_l, gcu_set_ram_ptr} = strb;

    // only one operation in flight, a start never lands on a pending strobe
    a_start_idle: assert property (@(posedge CLK96) disable iff (RESET96)
        gcu_start |-> !busy);

endmodule

/* rtl/host_bus_ctrl.sv */
// APB slave that decodes the 68000 map, issues RAM, I/O and GCU requests and muxes read data
`include "snowbro2_defines.svh"

module host_bus_ctrl (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  snowbro2_pkg::bus_addr_t  paddr,
    input  snowbro2_pkg::bus_data_t  pwdata,
    input  snowbro2_pkg::byte_strb_t pstrb,
    input  snowbro2_pkg::bus_data_t  wram_q,
    input  snowbro2_pkg::bus_data_t  pal_q,
    input  snowbro2_pkg::bus_data_t  io_rdata,
    input  logic                     gcu_done,
    input  snowbro2_pkg::bus_data_t  gcu_rdata,
    output snowbro2_pkg::bus_data_t  prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic [`SB2_WRAM_AW-1:0]  mem_addr,
    output snowbro2_pkg::bus_data_t  mem_wdata,
    output snowbro2_pkg::byte_strb_t wram_we,
    output snowbro2_pkg::byte_strb_t pal_we,
    output logic                     io_rd,
    output logic                     io_wr,
    output logic                     vstat_rd,
    output logic [11:0]              io_offset,
    output logic                     gcu_start,
    output logic [3:0]               gcu_offset,
    output logic                     gcu_read
);

    snowbro2_pkg::bus_state_e state;
    snowbro2_pkg::target_e    target;    // latched at setup
    logic                     in_wait;

    function automatic snowbro2_pkg::target_e decode(snowbro2_pkg::bus_addr_t a, logic wr);
        snowbro2_pkg::target_e t;
        t = snowbro2_pkg::TGT_NONE;
        if ((a & 24'hFF0000) == `SB2_WRAM_BASE) begin
            t = snowbro2_pkg::TGT_WRAM;
        end else if ((a & 24'hFFF000) == `SB2_PAL_BASE) begin
            t = snowbro2_pkg::TGT_PAL;
        end else if ((a & 24'hFFF000) == `SB2_IO_BASE) begin
            t = snowbro2_pkg::TGT_IO;
        end else if ((a & 24'hFFFFF0) == `SB2_GCU_BASE) begin
            // only offsets with a chip operation go to the GCU, others would never ack
            case (a[3:0])
                `SB2_GCU_PTR, `SB2_GCU_SEL:     t = wr ? snowbro2_pkg::TGT_GCU : snowbro2_pkg::TGT_NONE;
                `SB2_GCU_RAM_H, `SB2_GCU_RAM_L: t = snowbro2_pkg::TGT_GCU;
                `SB2_GCU_REG:                   t = wr ? snowbro2_pkg::TGT_GCU : snowbro2_pkg::TGT_VSTAT;
                default:                        t = snowbro2_pkg::TGT_NONE;
            endcase
        end
        return t;
    endfunction

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state   <= snowbro2_pkg::BUS_IDLE;
            target  <= snowbro2_pkg::TGT_NONE;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            case (state)
                snowbro2_pkg::BUS_IDLE: begin
                    if (psel && !penable) begin
                        target <= decode(paddr, pwrite);
                        state  <= snowbro2_pkg::BUS_WAIT;
                    end
                end
                snowbro2_pkg::BUS_WAIT: begin
                    if (target == snowbro2_pkg::TGT_GCU) begin
                        state <= snowbro2_pkg::BUS_GCU;
                    end else begin
                        state   <= snowbro2_pkg::BUS_DONE;   // fixed single wait state
                        pready  <= 1'b1;
                        pslverr <= (target == snowbro2_pkg::TGT_NONE);
                    end
                end
                snowbro2_pkg::BUS_GCU: begin
                    if (gcu_done) begin
                        state  <= snowbro2_pkg::BUS_DONE;
                        pready <= 1'b1;
                    end
                end
                default: state <= snowbro2_pkg::BUS_IDLE;
            endcase
        end
    end

    assign in_wait    = (state == snowbro2_pkg::BUS_WAIT);
    assign mem_addr   = paddr[`SB2_WRAM_AW:1];
    assign mem_wdata  = pwdata;
    assign io_offset  = paddr[11:0];
    assign gcu_offset = paddr[3:0];
    assign gcu_read   = !pwrite;

    // requests live for the first access cycle only
    assign wram_we   = (in_wait && pwrite && target == snowbro2_pkg::TGT_WRAM) ? pstrb : 2'b00;
    assign pal_we    = (in_wait && pwrite && target == snowbro2_pkg::TGT_PAL) ? pstrb : 2'b00;
    assign io_rd     = in_wait && !pwrite && (target == snowbro2_pkg::TGT_IO);
    assign io_wr     = in_wait && pwrite && (target == snowbro2_pkg::TGT_IO);
    assign vstat_rd  = in_wait && (target == snowbro2_pkg::TGT_VSTAT);
    assign gcu_start = in_wait && (target == snowbro2_pkg::TGT_GCU);

    always_comb begin
        prdata = '0;
        if (state == snowbro2_pkg::BUS_DONE && !pwrite) begin
            case (target)
                snowbro2_pkg::TGT_WRAM:  prdata = wram_q;
                snowbro2_pkg::TGT_PAL:   prdata = pal_q;
                snowbro2_pkg::TGT_GCU:   prdata = gcu_rdata;
                snowbro2_pkg::TGT_VSTAT: prdata = io_rdata;   // status comes through cabinet_io
                snowbro2_pkg::TGT_IO:    prdata = io_rdata;
                default:                 prdata = '0;
            endcase
        end
    end

    // requester must hold the address until the transfer completes
    a_paddr_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        (psel && !pready) |=> $stable(paddr));

    a_pready_psel: assert property (@(posedge CLK96) disable iff (RESET96)
        pready |-> psel);

endmodule

/* rtl/snowbro2_bus_top.sv */
// top of the 68000-side glue, joins the APB slave, both RAMs, cabinet I/O and GCU strobes
`include "snowbro2_defines.svh"

module snowbro2_bus_top (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  snowbro2_pkg::bus_addr_t  paddr,
    input  snowbro2_pkg::bus_data_t  pwdata,
    input  snowbro2_pkg::byte_strb_t pstrb,
    input  snowbro2_pkg::joy_t       joystick1,
    input  snowbro2_pkg::joy_t       joystick2,
    input  logic [1:0]               start_button,
    input  logic [1:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               v,
    input  logic                     gcu_ack,
    input  snowbro2_pkg::bus_data_t  gcu_dout,
    input  snowbro2_pkg::pal_addr_t  palram_addr,
    output snowbro2_pkg::bus_data_t  prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     gcu_select_reg,
    output logic                     gcu_write_reg,
    output logic                     gcu_write_ram,
    output logic                     gcu_read_ram_h,
    output logic                     gcu_read_ram_l,
    output logic                     gcu_set_ram_ptr,
    output snowbro2_pkg::bus_data_t  gcu_wdata,
    output snowbro2_pkg::bus_data_t  palram_data,
    output logic                     oki_bank
);

    logic [`SB2_WRAM_AW-1:0]  mem_addr;   // word address, shared by both RAMs
    snowbro2_pkg::bus_data_t  mem_wdata;
    snowbro2_pkg::byte_strb_t wram_we;
    snowbro2_pkg::byte_strb_t pal_we;
    snowbro2_pkg::bus_data_t  wram_q;
    snowbro2_pkg::bus_data_t  pal_q;
    snowbro2_pkg::bus_data_t  io_rdata;
    snowbro2_pkg::bus_data_t  gcu_rdata;
    logic                     io_rd;
    logic                     io_wr;
    logic                     vstat_rd;
    logic [11:0]              io_offset;
    logic                     gcu_start;
    logic [3:0]               gcu_offset;
    logic                     gcu_read;
    logic                     gcu_done;

    host_bus_ctrl u_host_bus_ctrl (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .wram_q     (wram_q),
        .pal_q      (pal_q),
        .io_rdata   (io_rdata),
        .gcu_done   (gcu_done),
        .gcu_rdata  (gcu_rdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .wram_we    (wram_we),
        .pal_we     (pal_we),
        .io_rd      (io_rd),
        .io_wr      (io_wr),
        .vstat_rd   (vstat_rd),
        .io_offset  (io_offset),
        .gcu_start  (gcu_start),
        .gcu_offset (gcu_offset),
        .gcu_read   (gcu_read)
    );

    // work RAM, host side only
    byte_ram #(.aw(`SB2_WRAM_AW)) u_wram (
        .CLK96 (CLK96),
        .addr0 (mem_addr),
        .data0 (mem_wdata),
        .we0   (wram_we),
        .addr1 (mem_addr),
        .q0    (wram_q),
        .q1    ()
    );

    // palette RAM, port 1 feeds the video side
    byte_ram #(.aw(`SB2_PAL_AW)) u_palram (
        .CLK96 (CLK96),
        .addr0 (mem_addr[`SB2_PAL_AW-1:0]),
        .data0 (mem_wdata),
        .we0   (pal_we),
        .addr1 (palram_addr),
        .q0    (pal_q),
        .q1    (palram_data)
    );

    cabinet_io u_cabinet_io (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .io_rd        (io_rd),
        .io_wr        (io_wr),
        .io_offset    (io_offset),
        .io_wdata     (mem_wdata),
        .io_strb      (pstrb),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .v            (v),
        .vstat_rd     (vstat_rd),
        .io_rdata     (io_rdata),
        .oki_bank     (oki_bank)
    );

    gcu_cmd u_gcu_cmd (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .gcu_start       (gcu_start),
        .gcu_offset      (gcu_offset),
        .gcu_read        (gcu_read),
        .wdata           (mem_wdata),
        .gcu_ack         (gcu_ack),
        .gcu_dout        (gcu_dout),
        .gcu_select_reg  (gcu_select_reg),
        .gcu_write_reg   (gcu_write_reg),
        .gcu_write_ram   (gcu_write_ram),
        .gcu_read_ram_h  (gcu_read_ram_h),
        .gcu_read_ram_l  (gcu_read_ram_l),
        .gcu_set_ram_ptr (gcu_set_ram_ptr),
        .gcu_wdata       (gcu_wdata),
        .gcu_done        (gcu_done),
        .gcu_rdata       (gcu_rdata)
    );

endmodule

/* verification/snowbro2_tb.sv */
// directed testbench for the 68000 glue, drives APB transfers and answers GP9001 strobes
`include "snowbro2_defines.svh"

module snowbro2_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 4;
    localparam int n_transfers = 72;   // sum over all tests below

    logic CLK96;
    logic RESET96;
    logic psel, penable, pwrite, pready, pslverr;
    snowbro2_pkg::bus_addr_t  paddr;
    snowbro2_pkg::bus_data_t  pwdata, prdata, gcu_dout, gcu_wdata, palram_data;
    snowbro2_pkg::byte_strb_t pstrb;
    snowbro2_pkg::joy_t       joystick1, joystick2;
    snowbro2_pkg::pal_addr_t  palram_addr;
    logic [1:0] start_button, coin_input;
    logic [7:0] dipsw_a, dipsw_b, dipsw_c;
    logic [8:0] v;
    logic service, dip_test, hsync, vsync, fblank, gcu_ack, oki_bank;
    logic gcu_select_reg, gcu_write_reg, gcu_write_ram;
    logic gcu_read_ram_h, gcu_read_ram_l, gcu_set_ram_ptr;
    logic [5:0] strobes;   // same order as the GCU op table
    int value_errors = 0;
    int other_errors = 0;
    int ack_count = 0;
    time ack_time, pready_time;
    logic [5:0] seen_strobes;
    snowbro2_pkg::bus_data_t seen_wdata, ack_dout;

    assign strobes = {gcu_select_reg, gcu_write_reg, gcu_write_ram,
                      gcu_read_ram_h, gcu_read_ram_l, gcu_set_ram_ptr};

    snowbro2_bus_top snowbro2_bus_top_i (.*);

    initial begin
        CLK96 = 1'b0;
        forever #(clk_period / 2) CLK96 = ~CLK96;
    end

    task automatic next_cycle;
        @(posedge CLK96);
        #1;
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            other_errors++;
            $display("%s", what);
        end
    endtask

    task automatic apb_transfer(input logic wr, input snowbro2_pkg::bus_addr_t addr,
                                input snowbro2_pkg::bus_data_t wdata,
                                input snowbro2_pkg::byte_strb_t strb,
                                output snowbro2_pkg::bus_data_t rdata,
                                output logic err, output int cycles);
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        next_cycle();
        penable = 1'b1;
        cycles  = 1;
        while (!pready && cycles < 40) begin
            next_cycle();
            cycles++;
        end
        check_true(pready === 1'b1, $sformatf("no pready for access to address %h", addr));
        pready_time = $time;
        rdata = prdata;
        err   = pslverr;
        next_cycle();   // transfer completes at this edge
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input snowbro2_pkg::bus_addr_t addr,
                             input snowbro2_pkg::bus_data_t data,
                             input snowbro2_pkg::byte_strb_t strb,
                             output logic err, output int cycles);
        snowbro2_pkg::bus_data_t unused;
        apb_transfer(1'b1, addr, data, strb, unused, err, cycles);
    endtask

    task automatic apb_read(input snowbro2_pkg::bus_addr_t addr,
                            output snowbro2_pkg::bus_data_t data,
                            output logic err, output int cycles);
        apb_transfer(1'b0, addr, '0, 2'b00, data, err, cycles);
    endtask

    // active-low joystick to the player byte, repeated in both halves
    function automatic snowbro2_pkg::bus_data_t player_word(input snowbro2_pkg::joy_t j);
        logic [7:0] b;
        b    = 8'h00;
        b[5] = ~j[5];
        b[4] = ~j[4];
        b[3] = ~j[0];
        b[2] = ~j[1];
        b[1] = ~j[2];
        b[0] = ~j[3];   // lowest bit comes from joystick bit 3
        return {b, b};
    endfunction

    // status word starts all ones, sync flags and beam line patched in
    function automatic snowbro2_pkg::bus_data_t status_word(input logic hs, input logic vs,
                                                            input logic fb,
                                                            input logic [8:0] line);
        snowbro2_pkg::bus_data_t w;
        w     = 16'hFFFF;
        w[15] = hs;
        w[14] = vs;
        w[8]  = fb;
        if (line <= 9'd255) begin
            w[7:0] = line[7:0];
        end
        return w;
    endfunction

    function automatic snowbro2_pkg::bus_data_t io_expected(input logic [11:0] off);
        logic [7:0] sys;
        sys    = 8'h00;
        sys[6] = ~start_button[1];
        sys[5] = ~start_button[0];
        sys[4] = ~coin_input[1];
        sys[3] = ~coin_input[0];
        sys[2] = ~dip_test;
        sys[0] = ~service;
        case (off)
            `SB2_IO_JUMPER: return {2{dipsw_c}};
            `SB2_IO_DSWA:   return {2{dipsw_a}};
            `SB2_IO_DSWB:   return {2{dipsw_b}};
            `SB2_IO_P1:     return player_word(joystick1);
            `SB2_IO_P2:     return player_word(joystick2);
            `SB2_IO_SYS:    return {dipsw_c, sys};
            default:        return '0;
        endcase
    endfunction

    task automatic test_wram;
        snowbro2_pkg::bus_addr_t  addr;
        snowbro2_pkg::bus_data_t  first, second, rdata;
        snowbro2_pkg::byte_strb_t strb;
        logic err;
        int cycles;
        for (int i = 0; i < 8; i++) begin
            addr   = `SB2_WRAM_BASE + 24'(($urandom % 32768) * 2);
            first  = 16'($urandom);
            second = 16'($urandom);
            strb   = 2'($urandom);
            apb_write(addr, first, 2'b11, err, cycles);
            apb_write(addr, second, strb, err, cycles);
            apb_read(addr, rdata, err, cycles);
            // lanes not written keep the first word
            check_value("prdata", {strb[1] ? second[15:8] : first[15:8],
                                   strb[0] ? second[7:0] : first[7:0]}, rdata);
            check_value("pslverr", 16'(1'b0), 16'(err));
            check_value("access_cycles", 16'd2, 16'(cycles));
        end
    endtask

    task automatic test_palette;
        snowbro2_pkg::pal_addr_t word;
        snowbro2_pkg::bus_data_t data, rdata;
        logic err;
        int cycles;
        for (int i = 0; i < 4; i++) begin
            word = 11'($urandom);
            data = 16'($urandom);
            apb_write(`SB2_PAL_BASE + 24'(word * 2), data, 2'b11, err, cycles);
            palram_addr = word;
            repeat (2) next_cycle();
            check_value("palram_data", data, palram_data);
            apb_read(`SB2_PAL_BASE + 24'(word * 2), rdata, err, cycles);
            check_value("prdata", data, rdata);
            check_value("access_cycles", 16'd2, 16'(cycles));
        end
    endtask

    task automatic test_cabinet;
        logic [11:0] offs [6] = '{`SB2_IO_JUMPER, `SB2_IO_DSWA, `SB2_IO_DSWB,
                                  `SB2_IO_P1, `SB2_IO_P2, `SB2_IO_SYS};
        logic [8:0] lines [6] = '{9'd0, 9'd100, 9'd255, 9'd256, 9'd300, 9'd511};
        snowbro2_pkg::bus_data_t rdata;
        logic err;
        int cycles;
        for (int r = 0; r < 2; r++) begin
            joystick1    = 10'($urandom);
            joystick2    = 10'($urandom);
            start_button = 2'($urandom);
            coin_input   = 2'($urandom);
            service      = 1'($urandom);
            dip_test     = 1'($urandom);
            dipsw_a      = 8'($urandom);
            dipsw_b      = 8'($urandom);
            dipsw_c      = 8'($urandom);
            for (int i = 0; i < 6; i++) begin
                apb_read(`SB2_IO_BASE + 24'(offs[i]), rdata, err, cycles);
                check_value($sformatf("prdata at io offset %h", offs[i]),
                            io_expected(offs[i]), rdata);
            end
        end
        foreach (lines[i]) begin
            v      = lines[i];
            hsync  = 1'($urandom);
            vsync  = 1'($urandom);
            fblank = 1'($urandom);
            apb_read(`SB2_GCU_BASE + 24'(`SB2_GCU_REG), rdata, err, cycles);
            check_value("video_status", status_word(hsync, vsync, fblank, lines[i]), rdata);
        end
    endtask

    task automatic test_gcu;
        logic [3:0] offs [7] = '{4'h0, 4'h4, 4'h6, 4'h8, 4'hC, 4'h4, 4'h6};
        logic       rd   [7] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        logic [5:0] want [7] = '{6'b000001, 6'b001000, 6'b001000, 6'b100000,
                                 6'b010000, 6'b000100, 6'b000010};
        snowbro2_pkg::bus_data_t data, rdata;
        logic err;
        int cycles, acks_before;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 7; i++) begin
                data = 16'($urandom);
                acks_before = ack_count;
                if (rd[i]) begin
                    apb_read(`SB2_GCU_BASE + 24'(offs[i]), rdata, err, cycles);
                    check_value("prdata", ack_dout, rdata);
                end else begin
                    apb_write(`SB2_GCU_BASE + 24'(offs[i]), data, 2'b11, err, cycles);
                    check_value("gcu_wdata", data, seen_wdata);
                end
                check_value("gcu_strobes", 16'(want[i]), 16'(seen_strobes));
                check_value("pslverr", 16'(1'b0), 16'(err));
                check_true(ack_count == acks_before + 1 && ack_time < pready_time,
                           "GCU access finished without its acknowledge coming first");
            end
        end
    endtask

    task automatic test_oki_unmapped;
        snowbro2_pkg::bus_addr_t bad [4] = '{24'h000000, 24'h200000, 24'h500000, 24'h300002};
        snowbro2_pkg::bus_data_t rdata;
        logic err;
        int cycles;
        apb_write(`SB2_IO_BASE + 24'(`SB2_IO_OKIBANK), 16'h0001, 2'b01, err, cycles);
        check_value("oki_bank", 16'd1, 16'(oki_bank));
        apb_write(`SB2_IO_BASE + 24'(`SB2_IO_OKIBANK), 16'h0000, 2'b10, err, cycles);
        check_value("oki_bank", 16'd1, 16'(oki_bank));   // low lane off, bank held
        apb_write(`SB2_IO_BASE + 24'(`SB2_IO_OKIBANK), 16'hFFFE, 2'b01, err, cycles);
        check_value("oki_bank", 16'd0, 16'(oki_bank));
        foreach (bad[i]) begin
            apb_read(bad[i], rdata, err, cycles);
            check_value("pslverr", 16'd1, 16'(err));
            check_value("prdata", 16'h0000, rdata);
            check_value("access_cycles", 16'd2, 16'(cycles));
        end
        apb_write(24'h800000, 16'hA5A5, 2'b11, err, cycles);
        check_value("pslverr", 16'd1, 16'(err));
    endtask

    // graphics chip model, acks each strobe after 1 to 8 cycles
    initial begin
        int delay;
        gcu_ack  = 1'b0;
        gcu_dout = '0;
        forever begin
            next_cycle();
            if (|strobes) begin
                seen_strobes = strobes;
                seen_wdata   = gcu_wdata;
                delay = 1 + ($urandom % 8);
                repeat (delay) begin
                    next_cycle();
                    check_true(strobes == seen_strobes, "GCU strobe changed before acknowledge");
                end
                gcu_ack  = 1'b1;
                gcu_dout = 16'($urandom);
                ack_dout = gcu_dout;
                ack_time = $time;
                ack_count++;
                next_cycle();
                gcu_ack = 1'b0;
                check_true(strobes == 6'b0, "GCU strobe still high after acknowledge");
            end
        end
    end

    initial begin
        #((n_transfers * 20 + 20) * clk_period);
        other_errors++;
        $display("timeout after %0d ns, transfers stopped completing", $time);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hd11));
        RESET96 = 1'b1;
        {psel, penable, pwrite, paddr, pwdata, pstrb} = '0;
        {joystick1, joystick2, start_button, coin_input} = '1;   // nothing pressed
        {service, dip_test, hsync, vsync, fblank} = '1;
        {dipsw_a, dipsw_b, dipsw_c, v, palram_addr} = '0;
        repeat (5) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;
        check_value("pready", 16'd0, 16'(pready));
        check_value("pslverr", 16'd0, 16'(pslverr));
        check_value("gcu_strobes", 16'd0, 16'(strobes));
        check_value("oki_bank", 16'd0, 16'(oki_bank));
        check_value("prdata", 16'd0, prdata);
        test_wram();
        test_palette();
        test_cabinet();
        test_gcu();
        test_oki_unmapped();
        repeat (2) next_cycle();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/snowbro2_pkg.sv
rtl/byte_ram.sv
io/cabinet_io.sv
gcu/gcu_cmd.sv
rtl/host_bus_ctrl.sv
rtl/snowbro2_bus_top.sv
verification/snowbro2_tb.sv

/* Bender.yml */
package:
  name: snowbro2_bus

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/snowbro2_pkg.sv
      - rtl/byte_ram.sv
      - io/cabinet_io.sv
      - gcu/gcu_cmd.sv
      - rtl/host_bus_ctrl.sv
      - rtl/snowbro2_bus_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/snowbro2_tb.sv
